/* verilog/eu_defines.svh */
//////////////////////////////////////////////////////////////////////
// event unit widths, register word offsets and address group codes
// included by the RTL and by the testbench
//////////////////////////////////////////////////////////////////////
`ifndef EU_DEFINES_SVH
`define EU_DEFINES_SVH

// widths and counts
`define EU_DATA_W    32
`define EU_ADDR_W    8
`define EU_NB_CORES  4
`define EU_NB_SW_EVT 8
`define EU_IRQ_ID_W  5

// upper nibble of the word address
`define EU_GRP_CORE   4'd0
`define EU_GRP_SW_EVT 4'd4

// core register offsets, lower nibble of the word address
`define EU_REG_EVT_MASK       4'd0
`define EU_REG_EVT_MASK_AND   4'd1
`define EU_REG_EVT_MASK_OR    4'd2
`define EU_REG_IRQ_MASK       4'd3
`define EU_REG_IRQ_MASK_AND   4'd4
`define EU_REG_IRQ_MASK_OR    4'd5
`define EU_REG_STATUS         4'd6
`define EU_REG_BUFFER         4'd7
`define EU_REG_BUF_MASKED     4'd8
`define EU_REG_BUF_IRQ_MASKED 4'd9
`define EU_REG_BUF_CLEAR      4'd10
`define EU_REG_WAIT           4'd14
`define EU_REG_WAIT_CLEAR     4'd15

`endif

/* verilog/eu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types of the event unit: word address views, mask write
// operations and the core clock state
//////////////////////////////////////////////////////////////////////
`default_nettype none

package eu_pkg;

  // core register view of the word address
  typedef struct packed {
    logic [3:0] grp;
    logic [3:0] offset;
  } eu_core_addr_t;

  // software event trigger view, the id selects one of eight events
  typedef struct packed {
    logic [3:0] grp;
    logic       rsvd;
    logic [2:0] evt_id;
  } eu_sw_addr_t;

  typedef union packed {
    eu_core_addr_t core;
    eu_sw_addr_t   sw;
  } eu_addr_u;

  // how a mask register takes the write data
  typedef enum logic [1:0] {
    WR_LOAD       = 2'd0,
    WR_CLEAR_BITS = 2'd1,
    WR_SET_BITS   = 2'd2
  } eu_wr_op_e;

  typedef enum logic {
    CLK_ACTIVE = 1'b0,
    CLK_SLEEP  = 1'b1
  } eu_clk_state_e;

endpackage

`default_nettype wire

/* verilog/eu_bus_port.sv */
//////////////////////////////////////////////////////////////////////
// register bus slave of the event unit with decode, grant, one cycle
// read response and the software event trigger
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "eu_defines.svh"

module eu_bus_port (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // core side bus where wen_i high means read
  input  logic                     req_i,
  input  logic                     wen_i,
  input  eu_pkg::eu_addr_u         add_i,
  input  logic [`EU_DATA_W-1:0]    wdata_i,
  output logic                     gnt_o,
  output logic                     r_valid_o,
  output logic [`EU_DATA_W-1:0]    r_rdata_o,
  // register state for the read mux
  input  logic [`EU_DATA_W-1:0]    evt_mask_i,
  input  logic [`EU_DATA_W-1:0]    irq_mask_i,
  input  logic [`EU_DATA_W-1:0]    buffer_i,
  input  logic [`EU_DATA_W-1:0]    buffer_masked_i,
  input  logic [`EU_DATA_W-1:0]    irq_masked_i,
  input  logic                     clock_en_i,
  // sleep controller
  input  logic                     hold_i,
  output logic                     wait_req_o,
  output logic                     wait_clear_o,
  // register writes that take effect at the next edge
  output logic                     wr_evt_mask_o,
  output logic                     wr_irq_mask_o,
  output logic                     clr_buffer_o,
  output eu_pkg::eu_wr_op_e        wr_op_o,
  output logic [`EU_DATA_W-1:0]    wr_data_o,
  // software events toward the other cores
  output logic [`EU_NB_SW_EVT-1:0] sw_events_o,
  output logic [`EU_NB_CORES-1:0]  sw_events_mask_o
);

  import eu_pkg::*;

  logic                    is_core_grp;
  logic                    is_wait_addr;
  logic [`EU_NB_CORES-1:0] core_mask;
  logic                    rd_valid_q;
  logic                    rd_read_q;
  eu_addr_u                rd_addr_q;

  assign is_core_grp  = (add_i.core.grp == `EU_GRP_CORE);
  assign is_wait_addr = is_core_grp && ((add_i.core.offset == `EU_REG_WAIT) ||
                                        (add_i.core.offset == `EU_REG_WAIT_CLEAR));

  assign wait_req_o   = req_i && wen_i && is_wait_addr;
  assign wait_clear_o = wait_req_o && (add_i.core.offset == `EU_REG_WAIT_CLEAR);

  // hold only ever comes back for a wait read
  assign gnt_o = req_i && !hold_i;

  assign wr_data_o = wdata_i;

  // an all-zero core mask targets every core
  assign core_mask = (wdata_i[`EU_NB_CORES-1:0] == '0) ? '1 : wdata_i[`EU_NB_CORES-1:0];

  always_comb begin
    wr_evt_mask_o    = 1'b0;
    wr_irq_mask_o    = 1'b0;
    clr_buffer_o     = 1'b0;
    wr_op_o          = WR_LOAD;
    sw_events_o      = '0;
    sw_events_mask_o = '0;

    if (gnt_o && !wen_i) begin
      if (is_core_grp) begin
        case (add_i.core.offset)
          `EU_REG_EVT_MASK: wr_evt_mask_o = 1'b1;
          `EU_REG_EVT_MASK_AND: begin
            wr_evt_mask_o = 1'b1;
            wr_op_o       = WR_CLEAR_BITS;
          end
          `EU_REG_EVT_MASK_OR: begin
            wr_evt_mask_o = 1'b1;
            wr_op_o       = WR_SET_BITS;
          end
          `EU_REG_IRQ_MASK: wr_irq_mask_o = 1'b1;
          `EU_REG_IRQ_MASK_AND: begin
            wr_irq_mask_o = 1'b1;
            wr_op_o       = WR_CLEAR_BITS;
          end
          `EU_REG_IRQ_MASK_OR: begin
            wr_irq_mask_o = 1'b1;
            wr_op_o       = WR_SET_BITS;
          end
          `EU_REG_BUF_CLEAR: clr_buffer_o = 1'b1;
          default: ;
        endcase
      end else if (add_i.sw.grp == `EU_GRP_SW_EVT) begin
        sw_events_o[add_i.sw.evt_id] = 1'b1;
        sw_events_mask_o             = core_mask;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
      rd_read_q  <= 1'b0;
    end else begin
      rd_valid_q <= gnt_o;
      rd_read_q  <= gnt_o && wen_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o && wen_i) begin
      rd_addr_q <= add_i;
    end
  end

  assign r_valid_o = rd_valid_q;

  // read data only in the response cycle of a read
  always_comb begin
    r_rdata_o = '0;
    if (rd_read_q && (rd_addr_q.core.grp == `EU_GRP_CORE)) begin
      case (rd_addr_q.core.offset)
        `EU_REG_EVT_MASK:       r_rdata_o = evt_mask_i;
        `EU_REG_IRQ_MASK:       r_rdata_o = irq_mask_i;
        `EU_REG_STATUS:         r_rdata_o = {{(`EU_DATA_W-1){1'b0}}, clock_en_i};
        `EU_REG_BUFFER:         r_rdata_o = buffer_i;
        `EU_REG_BUF_IRQ_MASKED: r_rdata_o = irq_masked_i;
        `EU_REG_BUF_MASKED,
        `EU_REG_WAIT,
        `EU_REG_WAIT_CLEAR:     r_rdata_o = buffer_masked_i;
        default:                r_rdata_o = '0;
      endcase
    end
  end

  // a grant always answers a live request
  a_gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_o |-> req_i);

endmodule

`default_nettype wire

/* verilog/eu_event_regs.sv */
//////////////////////////////////////////////////////////////////////
// event mask, interrupt mask and event buffer of one core
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "eu_defines.svh"

module eu_event_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  wr_evt_mask_i,
  input  logic                  wr_irq_mask_i,
  input  logic                  clr_buffer_i,
  input  eu_pkg::eu_wr_op_e     wr_op_i,
  input  logic [`EU_DATA_W-1:0] wr_data_i,
  input  logic [`EU_DATA_W-1:0] event_lines_i,
  input  logic                  wait_clear_i,
  input  logic [`EU_DATA_W-1:0] irq_clear_mask_i,
  output logic [`EU_DATA_W-1:0] evt_mask_o,
  output logic [`EU_DATA_W-1:0] irq_mask_o,
  output logic [`EU_DATA_W-1:0] buffer_o,
  output logic [`EU_DATA_W-1:0] buffer_masked_o
);

  import eu_pkg::*;

  logic [`EU_DATA_W-1:0] evt_mask_q;
  logic [`EU_DATA_W-1:0] irq_mask_q;
  logic [`EU_DATA_W-1:0] buffer_q;
  logic [`EU_DATA_W-1:0] buffer_d;
  logic [`EU_DATA_W-1:0] drop_bits;

  function automatic logic [`EU_DATA_W-1:0] apply_op(input logic [`EU_DATA_W-1:0] cur,
                                                     input eu_wr_op_e             op,
                                                     input logic [`EU_DATA_W-1:0] data);
    case (op)
      WR_CLEAR_BITS: return cur & ~data;
      WR_SET_BITS:   return cur | data;
      default:       return data;
    endcase
  endfunction

  // bits leaving the buffer this cycle
  // a wait_clear removes everything the event mask lets through
  assign drop_bits = (clr_buffer_i ? wr_data_i : '0) |
                     (wait_clear_i ? evt_mask_q : '0) |
                     irq_clear_mask_i;

  // new events are taken in before the clears apply
  assign buffer_d = (buffer_q | event_lines_i) & ~drop_bits;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_mask_q <= '0;
      irq_mask_q <= '0;
      buffer_q   <= '0;
    end else begin
      if (wr_evt_mask_i) begin
        evt_mask_q <= apply_op(evt_mask_q, wr_op_i, wr_data_i);
      end
      if (wr_irq_mask_i) begin
        irq_mask_q <= apply_op(irq_mask_q, wr_op_i, wr_data_i);
      end
      buffer_q <= buffer_d;
    end
  end

  assign evt_mask_o      = evt_mask_q;
  assign irq_mask_o      = irq_mask_q;
  assign buffer_o        = buffer_q;
  assign buffer_masked_o = buffer_q & evt_mask_q;

endmodule

`default_nettype wire

/* verilog/eu_irq_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// interrupt request to the core, highest masked buffer bit wins,
// the acknowledge turns back into a one-hot buffer clear
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "eu_defines.svh"

module eu_irq_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`EU_DATA_W-1:0]  buffer_i,
  input  logic [`EU_DATA_W-1:0]  irq_mask_i,
  input  logic                   irq_ack_i,
  input  logic [`EU_IRQ_ID_W-1:0] irq_ack_id_i,
  output logic [`EU_DATA_W-1:0]  irq_masked_o,
  output logic                   irq_pending_o,
  output logic                   irq_req_o,
  output logic [`EU_IRQ_ID_W-1:0] irq_id_o,
  output logic [`EU_DATA_W-1:0]  irq_clear_mask_o
);

  logic irq_req_q;

  assign irq_masked_o  = buffer_i & irq_mask_i;
  assign irq_pending_o = |irq_masked_o;

  // leading one search, later hits overwrite lower ones
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < `EU_DATA_W; i++) begin
      if (irq_masked_o[i]) begin
        irq_id_o = i[`EU_IRQ_ID_W-1:0];
      end
    end
  end

  assign irq_clear_mask_o = irq_ack_i ?
                            ({{(`EU_DATA_W-1){1'b0}}, 1'b1} << irq_ack_id_i) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_req_q <= 1'b0;
    end else begin
      irq_req_q <= irq_pending_o;
    end
  end

  assign irq_req_o = irq_req_q;

  // the id offered with a request always names a pending source
  a_irq_id_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_req_o && irq_pending_o) |-> irq_masked_o[irq_id_o]);

endmodule

`default_nettype wire

/* verilog/eu_sleep_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// core clock gating for wait and wait_clear reads, holds the grant
// until a masked event arrives
//////////////////////////////////////////////////////////////////////
`default_nettype none

module eu_sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic wait_req_i,
  input  logic wait_clear_i,
  input  logic event_pending_i,
  input  logic irq_pending_i,
  input  logic core_busy_i,
  output logic hold_o,
  output logic wait_clear_o,
  output logic clock_en_o
);

  import eu_pkg::*;

  eu_clk_state_e state_q;
  eu_clk_state_e state_d;
  logic          wait_clear_q;
  logic          wait_clear_d;

  always_comb begin
    state_d      = state_q;
    hold_o       = 1'b0;
    clock_en_o   = 1'b1;
    wait_clear_d = 1'b0;

    case (state_q)
      CLK_ACTIVE: begin
        if (wait_req_i) begin
          if (wait_clear_q) begin
            // last wait_clear has not reached the buffer yet
            hold_o = 1'b1;
          end else if (event_pending_i) begin
            wait_clear_d = wait_clear_i;
          end else if (irq_pending_i) begin
            // stay awake, the core takes the interrupt and replays the wait
            hold_o = 1'b1;
          end else begin
            hold_o = 1'b1;
            if (!core_busy_i) begin
              state_d = CLK_SLEEP;
            end
          end
        end
      end
      CLK_SLEEP: begin
        if (event_pending_i) begin
          // release the frozen wait read in the wake-up cycle
          wait_clear_d = wait_clear_i;
          state_d      = CLK_ACTIVE;
        end else if (irq_pending_i) begin
          hold_o  = 1'b1;
          state_d = CLK_ACTIVE;
        end else begin
          hold_o     = 1'b1;
          clock_en_o = 1'b0;
        end
      end
      default: state_d = CLK_ACTIVE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= CLK_ACTIVE;
      wait_clear_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      wait_clear_q <= wait_clear_d;
    end
  end

  assign wait_clear_o = wait_clear_q;

  // a gated clock always comes with a withheld wait grant
  a_clk_off_asleep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !clock_en_o |-> (state_q == CLK_SLEEP) && hold_o);

endmodule

`default_nettype wire

/* verilog/eu_top.sv */
//////////////////////////////////////////////////////////////////////
// per-core event unit, connects bus port, event registers,
// interrupt control and sleep control
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "eu_defines.svh"

module eu_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // register bus from the core
  input  logic                     req_i,
  input  logic                     wen_i,
  input  eu_pkg::eu_addr_u         add_i,
  input  logic [`EU_DATA_W-1:0]    wdata_i,
  output logic                     gnt_o,
  output logic                     r_valid_o,
  output logic [`EU_DATA_W-1:0]    r_rdata_o,
  // events and interrupts
  input  logic [`EU_DATA_W-1:0]    event_lines_i,
  output logic                     irq_req_o,
  output logic [`EU_IRQ_ID_W-1:0]  irq_id_o,
  input  logic                     irq_ack_i,
  input  logic [`EU_IRQ_ID_W-1:0]  irq_ack_id_i,
  // software events and core clock
  output logic [`EU_NB_SW_EVT-1:0] sw_events_o,
  output logic [`EU_NB_CORES-1:0]  sw_events_mask_o,
  input  logic                     core_busy_i,
  output logic                     core_clock_en_o
);

  import eu_pkg::*;

  logic [`EU_DATA_W-1:0] evt_mask;
  logic [`EU_DATA_W-1:0] irq_mask;
  logic [`EU_DATA_W-1:0] buffer;
  logic [`EU_DATA_W-1:0] buffer_masked;
  logic [`EU_DATA_W-1:0] irq_masked;
  logic [`EU_DATA_W-1:0] irq_clear_mask;
  logic                  irq_pending;
  logic                  wr_evt_mask;
  logic                  wr_irq_mask;
  logic                  clr_buffer;
  eu_wr_op_e             wr_op;
  logic [`EU_DATA_W-1:0] wr_data;
  logic                  wait_req;
  logic                  wait_clear_req;
  logic                  wait_clear_pulse;
  logic                  hold;

  eu_bus_port bus_port_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .wen_i            (wen_i),
    .add_i            (add_i),
    .wdata_i          (wdata_i),
    .gnt_o            (gnt_o),
    .r_valid_o        (r_valid_o),
    .r_rdata_o        (r_rdata_o),
    .evt_mask_i       (evt_mask),
    .irq_mask_i       (irq_mask),
    .buffer_i         (buffer),
    .buffer_masked_i  (buffer_masked),
    .irq_masked_i     (irq_masked),
    .clock_en_i       (core_clock_en_o),
    .hold_i           (hold),
    .wait_req_o       (wait_req),
    .wait_clear_o     (wait_clear_req),
    .wr_evt_mask_o    (wr_evt_mask),
    .wr_irq_mask_o    (wr_irq_mask),
    .clr_buffer_o     (clr_buffer),
    .wr_op_o          (wr_op),
    .wr_data_o        (wr_data),
    .sw_events_o      (sw_events_o),
    .sw_events_mask_o (sw_events_mask_o)
  );

  eu_event_regs event_regs_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .wr_evt_mask_i    (wr_evt_mask),
    .wr_irq_mask_i    (wr_irq_mask),
    .clr_buffer_i     (clr_buffer),
    .wr_op_i          (wr_op),
    .wr_data_i        (wr_data),
    .event_lines_i    (event_lines_i),
    .wait_clear_i     (wait_clear_pulse),
    .irq_clear_mask_i (irq_clear_mask),
    .evt_mask_o       (evt_mask),
    .irq_mask_o       (irq_mask),
    .buffer_o         (buffer),
    .buffer_masked_o  (buffer_masked)
  );

  eu_irq_ctrl irq_ctrl_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .buffer_i         (buffer),
    .irq_mask_i       (irq_mask),
    .irq_ack_i        (irq_ack_i),
    .irq_ack_id_i     (irq_ack_id_i),
    .irq_masked_o     (irq_masked),
    .irq_pending_o    (irq_pending),
    .irq_req_o        (irq_req_o),
    .irq_id_o         (irq_id_o),
    .irq_clear_mask_o (irq_clear_mask)
  );

  eu_sleep_ctrl sleep_ctrl_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .wait_req_i       (wait_req),
    .wait_clear_i     (wait_clear_req),
    .event_pending_i  (|buffer_masked),
    .irq_pending_i    (irq_pending),
    .core_busy_i      (core_busy_i),
    .hold_o           (hold),
    .wait_clear_o     (wait_clear_pulse),
    .clock_en_o       (core_clock_en_o)
  );

endmodule

`default_nettype wire

/* verif/eu_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench of the event unit that checks random bus, event, interrupt,
// trigger and wait traffic against a register model
//////////////////////////////////////////////////////////////////////
`default_nettype none
`include "eu_defines.svh"

module eu_tb;

  import eu_pkg::*;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     req_i;
  logic                     wen_i;
  eu_addr_u                 add_i;
  logic [`EU_DATA_W-1:0]    wdata_i;
  logic                     gnt_o;
  logic                     r_valid_o;
  logic [`EU_DATA_W-1:0]    r_rdata_o;
  logic [`EU_DATA_W-1:0]    event_lines_i;
  logic                     irq_req_o;
  logic [`EU_IRQ_ID_W-1:0]  irq_id_o;
  logic                     irq_ack_i;
  logic [`EU_IRQ_ID_W-1:0]  irq_ack_id_i;
  logic [`EU_NB_SW_EVT-1:0] sw_events_o;
  logic [`EU_NB_CORES-1:0]  sw_events_mask_o;
  logic                     core_busy_i;
  logic                     core_clock_en_o;

  // model of the masks and the event buffer
  logic [`EU_DATA_W-1:0] m_evt;
  logic [`EU_DATA_W-1:0] m_irq;
  logic [`EU_DATA_W-1:0] m_buf;

  int    seed;
  int    checks;
  int    errors;
  int    test_errs;
  int    tests_run;
  int    tests_failed;
  bit    timeout_hit;
  string test_name;

  eu_top eu_top_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .wen_i            (wen_i),
    .add_i            (add_i),
    .wdata_i          (wdata_i),
    .gnt_o            (gnt_o),
    .r_valid_o        (r_valid_o),
    .r_rdata_o        (r_rdata_o),
    .event_lines_i    (event_lines_i),
    .irq_req_o        (irq_req_o),
    .irq_id_o         (irq_id_o),
    .irq_ack_i        (irq_ack_i),
    .irq_ack_id_i     (irq_ack_id_i),
    .sw_events_o      (sw_events_o),
    .sw_events_mask_o (sw_events_mask_o),
    .core_busy_i      (core_busy_i),
    .core_clock_en_o  (core_clock_en_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [`EU_ADDR_W-1:0] core_addr(input logic [3:0] offset);
    return {`EU_GRP_CORE, offset};
  endfunction

  // top-down scan for the expected interrupt id
  function automatic logic [`EU_IRQ_ID_W-1:0] highest_bit(input logic [`EU_DATA_W-1:0] vec);
    for (int i = `EU_DATA_W - 1; i >= 0; i--) begin
      if (vec[i]) begin
        return i[`EU_IRQ_ID_W-1:0];
      end
    end
    return '0;
  endfunction

  task automatic check_data(input string name, input logic [`EU_DATA_W-1:0] got,
                            input logic [`EU_DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input logic [`EU_IRQ_ID_W-1:0] got,
                          input logic [`EU_IRQ_ID_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    errors++;
    test_errs++;
    timeout_hit = 1'b1;
    $display("test %s stopped, no %s arrived in time (t=%0t)", test_name, what, $time);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, test_name, test_errs);
    end
  endtask

  task automatic model_write(input logic [`EU_ADDR_W-1:0] addr,
                             input logic [`EU_DATA_W-1:0] data);
    if (addr[7:4] == `EU_GRP_CORE) begin
      case (addr[3:0])
        `EU_REG_EVT_MASK:     m_evt = data;
        `EU_REG_EVT_MASK_AND: m_evt = m_evt & ~data;
        `EU_REG_EVT_MASK_OR:  m_evt = m_evt | data;
        `EU_REG_IRQ_MASK:     m_irq = data;
        `EU_REG_IRQ_MASK_AND: m_irq = m_irq & ~data;
        `EU_REG_IRQ_MASK_OR:  m_irq = m_irq | data;
        `EU_REG_BUF_CLEAR:    m_buf = m_buf & ~data;
        default: ;
      endcase
    end
  endtask

  task automatic drive_req(input logic rd, input logic [`EU_ADDR_W-1:0] addr,
                           input logic [`EU_DATA_W-1:0] data);
    @(negedge clk_i);
    req_i   = 1'b1;
    wen_i   = rd;
    add_i   = addr;
    wdata_i = data;
  endtask

  // gnt is combinational and sampled just after the falling edge
  task automatic wait_gnt(input int max_cycles, output bit ok);
    ok = 1'b0;
    for (int n = 0; n < max_cycles; n++) begin
      #1;
      if (gnt_o) begin
        ok = 1'b1;
        break;
      end
      @(negedge clk_i);
    end
  endtask

  // the response belongs in the cycle right after the grant
  task automatic wait_rvalid(output logic [`EU_DATA_W-1:0] rdata, output bit ok);
    ok    = 1'b0;
    rdata = '0;
    for (int n = 1; n <= 4; n++) begin
      @(negedge clk_i);
      req_i = 1'b0;
      if (n == 1) begin
        check_bit("r_valid_o", r_valid_o, 1'b1);
      end
      if (r_valid_o) begin
        ok    = 1'b1;
        rdata = r_rdata_o;
        break;
      end
    end
  endtask

  task automatic bus_access(input logic rd, input logic [`EU_ADDR_W-1:0] addr,
                            input logic [`EU_DATA_W-1:0] data,
                            output logic [`EU_DATA_W-1:0] rdata, output bit ok);
    rdata = '0;
    ok    = 1'b0;
    if (timeout_hit) begin
      return;
    end
    drive_req(rd, addr, data);
    wait_gnt(8, ok);
    if (!ok) begin
      note_timeout("grant");
      req_i = 1'b0;
      return;
    end
    // the bus was idle in the cycle before this request
    check_bit("r_valid_o", r_valid_o, 1'b0);
    if (!rd) begin
      model_write(addr, data);
    end
    wait_rvalid(rdata, ok);
    if (!ok) begin
      note_timeout("r_valid");
      return;
    end
    if (!rd) begin
      check_data("r_rdata_o", rdata, '0);
    end
  endtask

  task automatic write_reg(input logic [3:0] offset, input logic [`EU_DATA_W-1:0] data);
    logic [`EU_DATA_W-1:0] rdata;
    bit                    ok;
    bus_access(1'b0, core_addr(offset), data, rdata, ok);
  endtask

  task automatic read_check(input logic [3:0] offset, input string name,
                            input logic [`EU_DATA_W-1:0] exp);
    logic [`EU_DATA_W-1:0] rdata;
    bit                    ok;
    bus_access(1'b1, core_addr(offset), '0, rdata, ok);
    if (ok) begin
      check_data(name, rdata, exp);
    end
  endtask

  task automatic pulse_events(input logic [`EU_DATA_W-1:0] lines);
    @(negedge clk_i);
    event_lines_i = lines;
    m_buf         = m_buf | lines;
    @(negedge clk_i);
    event_lines_i = '0;
  endtask

  task automatic test_masks();
    int unsigned           r;
    logic [3:0]            offset;
    logic [`EU_DATA_W-1:0] data;
    begin_test("mask writes");
    for (int i = 0; i < 24; i++) begin
      r      = $random(seed);
      r      = r % 6;
      offset = r[3:0];
      data   = $random(seed);
      write_reg(offset, data);
      read_check(`EU_REG_EVT_MASK, "evt_mask", m_evt);
      read_check(`EU_REG_IRQ_MASK, "irq_mask", m_irq);
    end
    end_test();
  endtask

  task automatic test_buffer();
    logic [`EU_DATA_W-1:0] lines;
    logic [`EU_DATA_W-1:0] data;
    begin_test("event buffer");
    write_reg(`EU_REG_BUF_CLEAR, '1);
    data = $random(seed);
    write_reg(`EU_REG_EVT_MASK, data);
    data = $random(seed);
    write_reg(`EU_REG_IRQ_MASK, data);
    for (int i = 0; i < 12; i++) begin
      lines = $random(seed);
      data  = $random(seed);
      pulse_events(lines & data);
      read_check(`EU_REG_BUFFER, "buffer", m_buf);
      read_check(`EU_REG_BUF_MASKED, "buffer_masked", m_buf & m_evt);
      read_check(`EU_REG_BUF_IRQ_MASKED, "buffer_irq_masked", m_buf & m_irq);
      if ((i % 3) == 2) begin
        data = $random(seed);
        write_reg(`EU_REG_BUF_CLEAR, data);
        read_check(`EU_REG_BUFFER, "buffer", m_buf);
      end
    end
    end_test();
  endtask

  task automatic test_irq();
    logic [`EU_DATA_W-1:0]   lines;
    logic [`EU_DATA_W-1:0]   vec;
    logic [`EU_IRQ_ID_W-1:0] id;
    logic                    prev_pend;
    begin_test("interrupt request and acknowledge");
    write_reg(`EU_REG_BUF_CLEAR, '1);
    lines = $random(seed);
    write_reg(`EU_REG_IRQ_MASK, lines | 32'h8000_0001);
    for (int i = 0; i < 10; i++) begin
      prev_pend = |(m_buf & m_irq);
      lines     = $random(seed);
      pulse_events(lines);
      vec = m_buf & m_irq;
      // request still shows the vector from before the pulse
      check_bit("irq_req_o", irq_req_o, prev_pend);
      if (vec != '0) begin
        check_id("irq_id_o", irq_id_o, highest_bit(vec));
      end
      @(negedge clk_i);
      check_bit("irq_req_o", irq_req_o, |vec);
      if (vec != '0) begin
        id           = highest_bit(vec);
        irq_ack_i    = 1'b1;
        irq_ack_id_i = id;
        m_buf        = m_buf & ~(32'd1 << id);
        @(negedge clk_i);
        irq_ack_i = 1'b0;
        read_check(`EU_REG_BUF_IRQ_MASKED, "buffer_irq_masked", m_buf & m_irq);
      end
    end
    end_test();
  endtask

  task automatic test_sw_events();
    int unsigned             r;
    logic [2:0]              evt_id;
    logic [`EU_NB_CORES-1:0] cmask;
    logic [`EU_DATA_W-1:0]   data;
    logic [`EU_DATA_W-1:0]   rdata;
    logic [`EU_DATA_W-1:0]   exp_mask;
    bit                      ok;
    begin_test("software event trigger");
    for (int i = 0; i < 12; i++) begin
      r      = $random(seed);
      evt_id = r[2:0];
      r      = $random(seed);
      cmask  = (i == 0) ? '0 : r[`EU_NB_CORES-1:0];
      data   = $random(seed);
      data[`EU_NB_CORES-1:0] = cmask;
      // zero core mask stands for every core
      exp_mask = (cmask == '0) ? {{(`EU_DATA_W-`EU_NB_CORES){1'b0}}, {`EU_NB_CORES{1'b1}}}
                               : {{(`EU_DATA_W-`EU_NB_CORES){1'b0}}, cmask};
      drive_req(1'b0, {`EU_GRP_SW_EVT, 1'b0, evt_id}, data);
      wait_gnt(8, ok);
      if (!ok) begin
        note_timeout("grant of the trigger write");
        req_i = 1'b0;
        break;
      end
      check_data("sw_events_o", {{(`EU_DATA_W-`EU_NB_SW_EVT){1'b0}}, sw_events_o},
                 32'd1 << evt_id);
      check_data("sw_events_mask_o", {{(`EU_DATA_W-`EU_NB_CORES){1'b0}}, sw_events_mask_o},
                 exp_mask);
      wait_rvalid(rdata, ok);
      if (!ok) begin
        note_timeout("r_valid of the trigger write");
        break;
      end
      // the pulse ends once the request has dropped
      #1;
      check_data("sw_events_o", {{(`EU_DATA_W-`EU_NB_SW_EVT){1'b0}}, sw_events_o}, '0);
      check_data("r_rdata_o", rdata, '0);
    end
    end_test();
  endtask

  task automatic wait_access(input logic clear);
    logic [`EU_DATA_W-1:0] lines;
    logic [`EU_DATA_W-1:0] rdata;
    logic [`EU_DATA_W-1:0] exp;
    bit                    ok;
    if (timeout_hit) begin
      return;
    end
    drive_req(1'b1, core_addr(clear ? `EU_REG_WAIT_CLEAR : `EU_REG_WAIT), '0);
    for (int n = 0; n < 4; n++) begin
      #1;
      check_bit("gnt_o", gnt_o, 1'b0);
      @(negedge clk_i);
    end
    check_bit("core_clock_en_o", core_clock_en_o, 1'b0);
    // one masked line plus random unmasked ones
    lines = $random(seed);
    lines = (lines & ~m_evt) | (m_evt & (~m_evt + 32'd1));
    event_lines_i = lines;
    m_buf         = m_buf | lines;
    @(negedge clk_i);
    event_lines_i = '0;
    wait_gnt(8, ok);
    if (!ok) begin
      note_timeout("grant of the wait read");
      req_i = 1'b0;
      return;
    end
    check_bit("r_valid_o", r_valid_o, 1'b0);
    exp = m_buf & m_evt;
    wait_rvalid(rdata, ok);
    if (!ok) begin
      note_timeout("r_valid of the wait read");
      return;
    end
    check_data("r_rdata_o", rdata, exp);
    check_bit("core_clock_en_o", core_clock_en_o, 1'b1);
    if (clear) begin
      m_buf = m_buf & ~m_evt;
    end
  endtask

  task automatic test_wait();
    logic [`EU_DATA_W-1:0] data;
    begin_test("wait and wait_clear");
    write_reg(`EU_REG_IRQ_MASK, '0);
    data = $random(seed);
    write_reg(`EU_REG_EVT_MASK, data | 32'h1);
    write_reg(`EU_REG_BUF_CLEAR, '1);
    wait_access(1'b0);
    // masked event still pending from the last wait
    read_check(`EU_REG_WAIT, "wait r_rdata_o", m_buf & m_evt);
    write_reg(`EU_REG_BUF_CLEAR, '1);
    wait_access(1'b1);
    read_check(`EU_REG_BUFFER, "buffer", m_buf);
    read_check(`EU_REG_BUF_MASKED, "buffer_masked", m_buf & m_evt);
    end_test();
  endtask

  initial begin
    seed          = 72556;
    checks        = 0;
    errors        = 0;
    test_errs     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    timeout_hit   = 1'b0;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    wen_i         = 1'b0;
    add_i         = '0;
    wdata_i       = '0;
    event_lines_i = '0;
    irq_ack_i     = 1'b0;
    irq_ack_id_i  = '0;
    core_busy_i   = 1'b0;
    m_evt         = '0;
    m_irq         = '0;
    m_buf         = '0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    test_masks();
    test_buffer();
    test_irq();
    test_sw_events();
    test_wait();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if ((errors == 0) && !timeout_hit) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/eu_pkg.sv
verilog/eu_bus_port.sv
verilog/eu_event_regs.sv
verilog/eu_irq_ctrl.sv
verilog/eu_sleep_ctrl.sv
verilog/eu_top.sv
verif/eu_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build eu_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -f compile.f --top-module eu_tb -Mdir obj_dir
	./obj_dir/Veu_tb | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
